//--- rtl/rvviTracePkg.sv
package rvviTracePkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Register and address width of the traced hart
  parameter int Xlen   = 32;
  // Integer register file size, x0 included
  parameter int NumGpr = 32;
  // Retirement order counter, as wide as RVFI reports it
  parameter int OrderW = 64;
  // Tracked CSRs, one slot each
  parameter int NumCsr = 8;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [Xlen-1:0]           xlenT;
  typedef logic [OrderW-1:0]         orderT;
  typedef logic [$clog2(NumGpr)-1:0] gprIdxT;
  // Bit k set means register k was written
  typedef logic [NumGpr-1:0]         gprMaskT;

  // Privilege encoding as in the RISC-V privileged spec
  typedef enum logic [1:0] {
    PrivUser    = 2'b00,
    PrivSuper   = 2'b01,
    PrivRsvd    = 2'b10,
    PrivMachine = 2'b11
  } privModeE;

  // Slot order of the tracked CSRs in every csrVecT and csrMaskT
  typedef enum logic [2:0] {
    CsrMstatus  = 3'd0,
    CsrMie      = 3'd1,
    CsrMtvec    = 3'd2,
    CsrMscratch = 3'd3,
    CsrMepc     = 3'd4,
    CsrMcause   = 3'd5,
    CsrDcsr     = 3'd6,
    CsrDpc      = 3'd7
  } csrIdxE;

  // One word per slot, indexed by csrIdxE
  typedef xlenT [NumCsr-1:0] csrVecT;
  typedef logic [NumCsr-1:0] csrMaskT;

endpackage

//--- rtl/retireIf.sv
`timescale 1ns/1ns

// Registered retirement record between the capture stage and the
// two output stages
interface retireIf;
  import rvviTracePkg::*;

  // Record qualifier, everything else is meaningful only while high
  logic     valid;
  orderT    order;
  xlenT     insn;
  logic     trap;
  logic     intr;
  privModeE mode;
  xlenT     pc;

  // GPR writeback as reported by the core
  gprIdxT   rdAddr;
  xlenT     rdWdata;

  // Per-slot CSR read data, write data and write mask
  csrVecT   csrRdata;
  csrVecT   csrWdata;
  csrVecT   csrWmask;

  // Single writer
  modport capture (
    output valid, order, insn, trap, intr, mode, pc,
    output rdAddr, rdWdata, csrRdata, csrWdata, csrWmask
  );

  // Both second-stage blocks read the same record
  modport consume (
    input valid, order, insn, trap, intr, mode, pc,
    input rdAddr, rdWdata, csrRdata, csrWdata, csrWmask
  );

endinterface

//--- rtl/rvfiCapture.sv
`timescale 1ns/1ns

// Stage one flops the raw RVFI report so stage two works on a stable
// record of at most one retirement per cycle
module rvfiCapture (
  input  logic                   rvvi,
  input  logic                   rstN_i,
  // Retirement report from the core
  input  logic                   valid_i,
  input  rvviTracePkg::orderT    order_i,
  input  rvviTracePkg::xlenT     insn_i,
  input  logic                   trap_i,
  input  logic                   intr_i,
  input  rvviTracePkg::privModeE mode_i,
  input  rvviTracePkg::xlenT     pc_i,
  input  rvviTracePkg::gprIdxT   rdAddr_i,
  input  rvviTracePkg::xlenT     rdWdata_i,
  input  rvviTracePkg::csrVecT   csrRdata_i,
  input  rvviTracePkg::csrVecT   csrWdata_i,
  input  rvviTracePkg::csrVecT   csrWmask_i,
  // Registered record towards stage two
  retireIf.capture               rec_o
);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  // Record qualifier
  always_ff @(posedge rvvi) begin
    if (!rstN_i) begin
      rec_o.valid <= 1'b0;
    end else begin
      rec_o.valid <= valid_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  // Payload taken every cycle
  // Back-to-back retirements simply overwrite the previous record
  always_ff @(posedge rvvi) begin
    rec_o.order    <= order_i;
    rec_o.insn     <= insn_i;
    rec_o.trap     <= trap_i;
    rec_o.intr     <= intr_i;
    rec_o.mode     <= mode_i;
    rec_o.pc       <= pc_i;
    // GPR writeback decoded in stage two
    rec_o.rdAddr   <= rdAddr_i;
    rec_o.rdWdata  <= rdWdata_i;
    // CSR triplets merged in stage two
    rec_o.csrRdata <= csrRdata_i;
    rec_o.csrWdata <= csrWdata_i;
    rec_o.csrWmask <= csrWmask_i;
  end

endmodule

//--- rtl/retireEmit.sv
`timescale 1ns/1ns

// Stage two, trace fields and GPR writeback decode
module retireEmit (
  input  logic                   rvvi,
  input  logic                   rstN_i,
  retireIf.consume               rec_i,
  output logic                   valid_o,
  output rvviTracePkg::orderT    order_o,
  output rvviTracePkg::xlenT     insn_o,
  output logic                   trap_o,
  output logic                   intr_o,
  output rvviTracePkg::privModeE mode_o,
  output rvviTracePkg::xlenT     pc_o,
  output rvviTracePkg::gprMaskT  xWb_o,
  output rvviTracePkg::xlenT     xWdata_o
);
  import rvviTracePkg::*;

  // Real writeback: valid record and a destination other than x0
  logic    wbHit;
  gprMaskT wbMask;

  always_comb begin
    wbHit  = rec_i.valid && (rec_i.rdAddr != '0);
    wbMask = '0;
    // One-hot on the destination index
    if (wbHit) begin
      wbMask[rec_i.rdAddr] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge rvvi) begin
    if (!rstN_i) begin
      valid_o <= 1'b0;
      xWb_o   <= '0;
    end else begin
      valid_o <= rec_i.valid;
      xWb_o   <= wbMask;
    end
  end

  // Plain pass-through of the trace fields
  always_ff @(posedge rvvi) begin
    order_o  <= rec_i.order;
    insn_o   <= rec_i.insn;
    trap_o   <= rec_i.trap;
    intr_o   <= rec_i.intr;
    mode_o   <= rec_i.mode;
    pc_o     <= rec_i.pc;
    // Data zeroed along with the mask for x0 or idle cycles
    xWdata_o <= wbHit ? rec_i.rdWdata : '0;
  end

endmodule

//--- rtl/csrTracker.sv
`timescale 1ns/1ns

// Stage two, CSR value rebuild and per-slot change flags
module csrTracker (
  input  logic                  rvvi,
  input  logic                  rstN_i,
  retireIf.consume              rec_i,
  output rvviTracePkg::csrVecT  csrValue_o,
  output rvviTracePkg::csrMaskT csrWb_o
);
  import rvviTracePkg::*;

  // Merged value of the current record, per slot
  csrVecT  merged;
  // Last value reported per slot
  csrVecT  shadowQ;
  // Slots whose merged value moved away from the shadow
  csrMaskT changed;

  //////////////////////////////////////////////////////////////////////
  // Merge
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < NumCsr; s++) begin
      // Written bits from wdata, the rest from rdata
      merged[s] = (rec_i.csrWdata[s] & rec_i.csrWmask[s]) |
                  (rec_i.csrRdata[s] & ~rec_i.csrWmask[s]);
      // Compared against what was reported last time
      changed[s] = (merged[s] != shadowQ[s]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shadow and flags
  //////////////////////////////////////////////////////////////////////

  // Shadow only moves on a valid record
  // Flags are a one-cycle report tied to that record
  always_ff @(posedge rvvi) begin
    if (!rstN_i) begin
      shadowQ <= '0;
      csrWb_o <= '0;
    end else if (rec_i.valid) begin
      shadowQ <= merged;
      csrWb_o <= changed;
    end else begin
      // Idle cycle, values hold and nothing is flagged
      csrWb_o <= '0;
    end
  end

  // Reported value is the shadow itself, so both stay in step
  assign csrValue_o = shadowQ;

endmodule

//--- rtl/netMonitor.sv
`timescale 1ns/1ns

// Change detection on the interrupt lines and the debug halt request
module netMonitor #(
  // Lines 3, 7, 11 and 16..31 by default
  parameter logic [31:0] IrqMask = 32'hFFFF_0888
) (
  input  logic        rvvi,
  input  logic        rstN_i,
  input  logic [31:0] irq_i,
  input  logic        debugReq_i,
  output logic [31:0] netLevel_o,
  output logic [31:0] netEvent_o,
  output logic        haltEvent_o
);

  // Sample taken at the previous edge
  logic [31:0] irqQ;
  logic        dbgQ;

  //////////////////////////////////////////////////////////////////////
  // Sampling and edge detect
  //////////////////////////////////////////////////////////////////////

  // New sample vs the last one, flopped in the same edge
  // so each change gives a single-cycle pulse
  always_ff @(posedge rvvi) begin
    if (!rstN_i) begin
      irqQ        <= '0;
      dbgQ        <= 1'b0;
      netEvent_o  <= '0;
      haltEvent_o <= 1'b0;
    end else begin
      irqQ        <= irq_i;
      dbgQ        <= debugReq_i;
      // Untracked lines are masked off here
      netEvent_o  <= (irq_i ^ irqQ) & IrqMask;
      haltEvent_o <= debugReq_i ^ dbgQ;
    end
  end

  // Level view of all lines, masked or not
  assign netLevel_o = irqQ;

endmodule

//--- rtl/rvviTraceTop.sv
`timescale 1ns/1ns

// RVFI to RVVI-style trace adapter
// Retirement path is two stages, net path is one
module rvviTraceTop #(
  parameter logic [31:0] IrqMask = 32'hFFFF_0888
) (
  input  logic                   rvvi,
  input  logic                   rstN_i,

  // RVFI retirement report
  input  logic                   valid_i,
  input  rvviTracePkg::orderT    order_i,
  input  rvviTracePkg::xlenT     insn_i,
  input  logic                   trap_i,
  input  logic                   intr_i,
  input  rvviTracePkg::privModeE mode_i,
  input  rvviTracePkg::xlenT     pc_i,
  input  rvviTracePkg::gprIdxT   rdAddr_i,
  input  rvviTracePkg::xlenT     rdWdata_i,
  input  rvviTracePkg::csrVecT   csrRdata_i,
  input  rvviTracePkg::csrVecT   csrWdata_i,
  input  rvviTracePkg::csrVecT   csrWmask_i,

  // Core request lines
  input  logic [31:0]            irq_i,
  input  logic                   debugReq_i,

  // Trace fields
  output logic                   valid_o,
  output rvviTracePkg::orderT    order_o,
  output rvviTracePkg::xlenT     insn_o,
  output logic                   trap_o,
  output logic                   intr_o,
  output rvviTracePkg::privModeE mode_o,
  output rvviTracePkg::xlenT     pc_o,
  output rvviTracePkg::gprMaskT  xWb_o,
  output rvviTracePkg::xlenT     xWdata_o,

  // CSR state
  output rvviTracePkg::csrVecT   csrValue_o,
  output rvviTracePkg::csrMaskT  csrWb_o,

  // Net events
  output logic [31:0]            netLevel_o,
  output logic [31:0]            netEvent_o,
  output logic                   haltEvent_o
);

  //////////////////////////////////////////////////////////////////////
  // Retirement pipeline
  //////////////////////////////////////////////////////////////////////

  // Stage-one record, shared by both stage-two blocks
  retireIf retire ();

  rvfiCapture capture0 (
    .rvvi       (rvvi),
    .rstN_i     (rstN_i),
    .valid_i    (valid_i),
    .order_i    (order_i),
    .insn_i     (insn_i),
    .trap_i     (trap_i),
    .intr_i     (intr_i),
    .mode_i     (mode_i),
    .pc_i       (pc_i),
    .rdAddr_i   (rdAddr_i),
    .rdWdata_i  (rdWdata_i),
    .csrRdata_i (csrRdata_i),
    .csrWdata_i (csrWdata_i),
    .csrWmask_i (csrWmask_i),
    .rec_o      (retire.capture)
  );

  retireEmit emit0 (
    .rvvi     (rvvi),
    .rstN_i   (rstN_i),
    .rec_i    (retire.consume),
    .valid_o  (valid_o),
    .order_o  (order_o),
    .insn_o   (insn_o),
    .trap_o   (trap_o),
    .intr_o   (intr_o),
    .mode_o   (mode_o),
    .pc_o     (pc_o),
    .xWb_o    (xWb_o),
    .xWdata_o (xWdata_o)
  );

  // Same stage as emit0, so flags line up with valid_o
  csrTracker csr0 (
    .rvvi       (rvvi),
    .rstN_i     (rstN_i),
    .rec_i      (retire.consume),
    .csrValue_o (csrValue_o),
    .csrWb_o    (csrWb_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Nets
  //////////////////////////////////////////////////////////////////////

  // Independent of retirement, one cycle
  netMonitor #(
    .IrqMask (IrqMask)
  ) net0 (
    .rvvi        (rvvi),
    .rstN_i      (rstN_i),
    .irq_i       (irq_i),
    .debugReq_i  (debugReq_i),
    .netLevel_o  (netLevel_o),
    .netEvent_o  (netEvent_o),
    .haltEvent_o (haltEvent_o)
  );

endmodule

//--- verif/rvviTraceSva.sv
`timescale 1ns/1ns

// Output rules that hold on every cycle out of reset
module rvviTraceSva #(
  parameter logic [31:0] IrqMask = 32'hFFFF_0888
) (
  input logic                  rvvi,
  input logic                  rstN_i,
  input logic                  valid_i,
  input rvviTracePkg::gprMaskT xWb_i,
  input rvviTracePkg::csrMaskT csrWb_i,
  input logic [31:0]           netEvent_i
);

  // At most one GPR per retirement, x0 never
  xWbOneHot: assert property (@(posedge rvvi) disable iff (!rstN_i)
    $onehot0(xWb_i) && !xWb_i[0])
    else $error("xWb_o 0x%h not one-hot or sets x0", xWb_i);

  // CSR flags belong to a valid record
  csrWbQual: assert property (@(posedge rvvi) disable iff (!rstN_i)
    !valid_i |-> csrWb_i == '0)
    else $error("csrWb_o 0x%h set without valid_o", csrWb_i);

  // Untracked lines stay quiet
  netInMask: assert property (@(posedge rvvi) disable iff (!rstN_i)
    (netEvent_i & ~IrqMask) == '0)
    else $error("netEvent_o 0x%h outside mask", netEvent_i);

endmodule

bind rvviTraceTop rvviTraceSva #(
  .IrqMask (IrqMask)
) sva0 (
  .rvvi       (rvvi),
  .rstN_i     (rstN_i),
  .valid_i    (valid_o),
  .xWb_i      (xWb_o),
  .csrWb_i    (csrWb_o),
  .netEvent_i (netEvent_o)
);

//--- verif/rvviTraceTb.sv
`timescale 1ns/1ns

module rvviTraceTb;
  import rvviTracePkg::*;

  // Narrower than the DUT default so some tracked lines are masked off
  localparam logic [31:0] TbIrqMask = 32'h0F0F_0888;
  localparam int NumRec  = 40;
  localparam int NumPass = 24;
  // Cycles of the reset, pass-through, GPR, CSR and net tests
  localparam int CycleLimit = 2 * (4 + (NumPass + 2) + (NumGpr + 3) + 12 + 74);

  // One retirement as the core reports it
  typedef struct {
    logic     valid;
    orderT    order;
    xlenT     insn;
    logic     trap;
    logic     intr;
    privModeE mode;
    xlenT     pc;
    gprIdxT   rdAddr;
    xlenT     rdWdata;
    csrVecT   rdata;
    csrVecT   wdata;
    csrVecT   wmask;
  } recT;

  // Signals named after the DUT ports
  logic        rvvi;
  logic        rstN_i;
  logic        valid_i, trap_i, intr_i, debugReq_i;
  orderT       order_i;
  xlenT        insn_i, pc_i, rdWdata_i;
  privModeE    mode_i;
  gprIdxT      rdAddr_i;
  csrVecT      csrRdata_i, csrWdata_i, csrWmask_i;
  logic [31:0] irq_i;
  logic        valid_o, trap_o, intr_o, haltEvent_o;
  orderT       order_o;
  xlenT        insn_o, pc_o, xWdata_o;
  privModeE    mode_o;
  gprMaskT     xWb_o;
  csrVecT      csrValue_o;
  csrMaskT     csrWb_o;
  logic [31:0] netLevel_o, netEvent_o;

  // Stimulus and reference state
  recT         stim [NumRec];
  csrVecT      shadowExp;
  logic [31:0] irqExp = '0;
  logic        dbgExp = 1'b0;
  int          checks = 0;
  int          errors = 0;
  int          testErrBase = 0;
  int          tests = 0;
  int          cycles = 0;

  rvviTraceTop #(
    .IrqMask (TbIrqMask)
  ) dut0 (.*);

  initial rvvi = 1'b0;
  always #50 rvvi = ~rvvi;

  // Run limit at twice the summed test lengths
  always @(posedge rvvi) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic tally(input bit ok, input string name, input string got, input string exp);
    checks++;
    if (!ok) begin
      errors++;
      $display("ERROR %s got 0x%s exp 0x%s", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic checkWord(input string name, input xlenT got, input xlenT exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic checkOrder(input string name, input orderT got, input orderT exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic checkMode(input string name, input privModeE got, input privModeE exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic checkGprMask(input string name, input gprMaskT got, input gprMaskT exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic checkCsrVec(input string name, input csrVecT got, input csrVecT exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic checkCsrMask(input string name, input csrMaskT got, input csrMaskT exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic finishTest(input string name);
    tests++;
    $display("test %s: %0d errors", name, errors - testErrBase);
    testErrBase = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and expected values
  //////////////////////////////////////////////////////////////////////

  function automatic logic randBit();
    return $urandom_range(1, 0) == 1;
  endfunction

  // About one record in four is idle
  function automatic recT randRecord();
    recT r;
    r.valid   = $urandom_range(3, 0) != 0;
    r.order   = {$urandom(), $urandom()};
    r.insn    = $urandom();
    r.trap    = randBit();
    r.intr    = randBit();
    r.mode    = privModeE'(2'($urandom_range(3, 0)));
    r.pc      = $urandom();
    r.rdAddr  = gprIdxT'($urandom_range(NumGpr - 1, 0));
    r.rdWdata = $urandom();
    for (int s = 0; s < NumCsr; s++) begin
      r.rdata[s] = $urandom();
      r.wdata[s] = $urandom();
      r.wmask[s] = $urandom();
    end
    return r;
  endfunction

  task automatic setRecord(input recT r);
    valid_i    <= r.valid;
    order_i    <= r.order;
    insn_i     <= r.insn;
    trap_i     <= r.trap;
    intr_i     <= r.intr;
    mode_i     <= r.mode;
    pc_i       <= r.pc;
    rdAddr_i   <= r.rdAddr;
    rdWdata_i  <= r.rdWdata;
    csrRdata_i <= r.rdata;
    csrWdata_i <= r.wdata;
    csrWmask_i <= r.wmask;
  endtask

  // Expected trace for a record driven two edges earlier
  task automatic checkRetire(input recT r);
    gprMaskT maskExp;
    xlenT    dataExp;
    csrVecT  merged;
    csrMaskT flagExp;
    maskExp = '0;
    dataExp = '0;
    flagExp = '0;
    checkBit("valid_o", valid_o, r.valid);
    if (r.valid) begin
      checkOrder("order_o", order_o, r.order);
      checkWord("insn_o", insn_o, r.insn);
      checkBit("trap_o", trap_o, r.trap);
      checkBit("intr_o", intr_o, r.intr);
      checkMode("mode_o", mode_o, r.mode);
      checkWord("pc_o", pc_o, r.pc);
      // No writeback reported for x0
      if (r.rdAddr != '0) begin
        maskExp[r.rdAddr] = 1'b1;
        dataExp = r.rdWdata;
      end
      // Masked bits come from wdata and the others from rdata
      for (int s = 0; s < NumCsr; s++) begin
        merged[s]  = (r.wdata[s] & r.wmask[s]) | (r.rdata[s] & ~r.wmask[s]);
        flagExp[s] = merged[s] != shadowExp[s];
      end
      shadowExp = merged;
    end
    checkGprMask("xWb_o", xWb_o, maskExp);
    checkWord("xWdata_o", xWdata_o, dataExp);
    checkCsrMask("csrWb_o", csrWb_o, flagExp);
    checkCsrVec("csrValue_o", csrValue_o, shadowExp);
  endtask

  // Back-to-back records followed by two idle cycles to drain the pipe
  task automatic runStream(input int n);
    recT r;
    for (int i = 0; i < n + 2; i++) begin
      r = stim[(i < n) ? i : n - 1];
      if (i >= n) begin
        r.valid = 1'b0;
      end
      @(posedge rvvi);
      setRecord(r);
      @(negedge rvvi);
      if (i >= 2) begin
        checkRetire(stim[i - 2]);
      end
    end
  endtask

  // One change on the lines over two cycles
  task automatic netStep(input logic [31:0] nextIrq, input logic nextDbg);
    logic [31:0] evExp;
    logic        haltExp;
    evExp   = (nextIrq ^ irqExp) & TbIrqMask;
    haltExp = nextDbg ^ dbgExp;
    @(posedge rvvi);
    irq_i      <= nextIrq;
    debugReq_i <= nextDbg;
    // Earlier pulse lasted a single cycle
    @(negedge rvvi);
    checkWord("netEvent_o", netEvent_o, '0);
    checkBit("haltEvent_o", haltEvent_o, 1'b0);
    @(negedge rvvi);
    checkWord("netEvent_o", netEvent_o, evExp);
    checkBit("haltEvent_o", haltEvent_o, haltExp);
    checkWord("netLevel_o", netLevel_o, nextIrq);
    irqExp = nextIrq;
    dbgExp = nextDbg;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // Live retirement and moving lines while reset is held
  task automatic testReset();
    recT r;
    r = randRecord();
    r.valid  = 1'b1;
    r.rdAddr = '1;
    setRecord(r);
    repeat (2) begin
      @(posedge rvvi);
      irq_i      <= ~irq_i;
      debugReq_i <= ~debugReq_i;
    end
    // Last edge in reset, inputs go quiet from here on
    @(posedge rvvi);
    rstN_i <= 1'b1;
    r.valid = 1'b0;
    setRecord(r);
    irq_i      <= '0;
    debugReq_i <= 1'b0;
    @(negedge rvvi);
    checkBit("valid_o", valid_o, 1'b0);
    checkGprMask("xWb_o", xWb_o, '0);
    checkCsrMask("csrWb_o", csrWb_o, '0);
    checkCsrVec("csrValue_o", csrValue_o, '0);
    checkWord("netEvent_o", netEvent_o, '0);
    checkWord("netLevel_o", netLevel_o, '0);
    checkBit("haltEvent_o", haltEvent_o, 1'b0);
    shadowExp = '0;
    finishTest("reset");
  endtask

  task automatic testPassThrough();
    for (int i = 0; i < NumPass; i++) begin
      stim[i] = randRecord();
    end
    runStream(NumPass);
    finishTest("passThrough");
  endtask

  // Every destination once including x0
  task automatic testGprWb();
    for (int k = 0; k < NumGpr; k++) begin
      stim[k] = randRecord();
      stim[k].valid  = 1'b1;
      stim[k].rdAddr = gprIdxT'(k);
    end
    // Idle slot with a live destination stays silent
    stim[NumGpr] = stim[5];
    stim[NumGpr].valid = 1'b0;
    runStream(NumGpr + 1);
    finishTest("gprWb");
  endtask

  task automatic testCsrMerge();
    for (int i = 0; i < 6; i++) begin
      stim[i] = randRecord();
      stim[i].valid = 1'b1;
    end
    // Repeated record flags no slot
    stim[6] = stim[5];
    // Fresh CSR data on an idle cycle must not move the values
    stim[7] = randRecord();
    stim[7].valid = 1'b0;
    stim[8] = stim[5];
    // Full write to mepc only
    stim[9] = stim[5];
    stim[9].wmask[CsrMepc] = '1;
    stim[9].wdata[CsrMepc] = ~stim[9].wdata[CsrMepc];
    runStream(10);
    finishTest("csrMerge");
  endtask

  task automatic testNets();
    // Raise one line at a time across masked and unmasked lines
    for (int j = 0; j < 32; j++) begin
      netStep(irqExp | (32'h1 << j), 1'b0);
    end
    // All lines drop while debug rises and then debug drops
    netStep('0, 1'b1);
    netStep('0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      netStep($urandom(), randBit());
    end
    finishTest("nets");
  endtask

  initial begin
    void'($urandom(32'h504a));
    rstN_i     <= 1'b0;
    irq_i      <= '0;
    debugReq_i <= 1'b0;
    testReset();
    testPassThrough();
    testGprWb();
    testCsrMerge();
    testNets();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/rvviTracePkg.sv
rtl/retireIf.sv
rtl/rvfiCapture.sv
rtl/retireEmit.sv
rtl/csrTracker.sv
rtl/netMonitor.sv
rtl/rvviTraceTop.sv
verif/rvviTraceSva.sv
verif/rvviTraceTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the trace adapter testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sim.f --top-module rvviTraceTb \
  -Mdir "$OBJ" -o rvviTraceSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/rvviTraceSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF "** PASS **" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
